/* verilog/x25519_defs.svh */
`ifndef X25519_DEFS_SVH
`define X25519_DEFS_SVH

// Bignum layout of a field element

// Number of blocks in one operand
`define X25519_BLOCKS 32

// Significant bits held in each block
`define X25519_BLOCK_W 8

// Storage width of a block, also the width of one pass column
`define X25519_WORD_W 32

// Operand width and the width of the partially reduced result
`define X25519_OPER_W 256
`define X25519_RES_W 264

`endif

/* verilog/x25519_pkg.sv */
`default_nettype none
`include "x25519_defs.svh"

package x25519_pkg;

	// Field element as 32 words, block 0 least significant
	// Only the low 8 bits of each word are significant on the way in
	typedef struct packed {
		logic [`X25519_BLOCKS-1:0][`X25519_WORD_W-1:0] blocks;
	} bignum_t;

	// Command opcodes
	typedef enum logic {
		MUL_OP_MUL = 1'b0,
		MUL_OP_SQR = 1'b1
	} mul_op_e;

	// Command register block states
	typedef enum logic {
		IDLE = 1'b0,
		RUN  = 1'b1
	} cmd_state_e;

	// Reducer states, one column stream then three fixed steps
	typedef enum logic [1:0] {
		COLLECT = 2'd0,
		CARRY1  = 2'd1,
		FOLD    = 2'd2,
		CARRY2  = 2'd3
	} squeeze_state_e;

endpackage

`default_nettype wire

/* verilog/mul_cmd_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "x25519_defs.svh"

module mul_cmd_regs import x25519_pkg::*; (
	input wire clk,
	input wire rst_n_i,
	input wire start_i,
	input wire mul_op_e op_i,
	input wire [`X25519_OPER_W-1:0] a_i,
	input wire [`X25519_OPER_W-1:0] b_i,
	input wire sq_valid_i,
	input wire [`X25519_RES_W-1:0] sq_result_i,
	output logic mult_en_o,
	output logic [`X25519_OPER_W-1:0] oper_a_o,
	output logic [`X25519_OPER_W-1:0] oper_b_o,
	output logic busy_o,
	output logic done_o,
	output logic [`X25519_RES_W-1:0] result_o
);

	cmd_state_e state_q;
	logic accept;

	// Starts only count while idle, anything else is dropped
	assign accept = start_i && (state_q == IDLE);
	assign busy_o = (state_q == RUN);

	//////////////////////////////////////////////////////////////////////
	// Control FSM

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q   <= IDLE;
			mult_en_o <= 1'b0;
			done_o    <= 1'b0;
		end else begin
			// Both strobes are single cycle
			mult_en_o <= accept;
			done_o    <= 1'b0;
			if (accept) begin
				state_q <= RUN;
			end else if ((state_q == RUN) && sq_valid_i) begin
				state_q <= IDLE;
				done_o  <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Operand and result registers

	always_ff @(posedge clk) begin
		// Operands stay put for the whole run
		if (accept) begin
			oper_a_o <= a_i;
			// Squaring feeds a into both multiplier inputs
			oper_b_o <= (op_i == MUL_OP_SQR) ? a_i : b_i;
		end
		// Result held until the next run finishes
		if ((state_q == RUN) && sq_valid_i)
			result_o <= sq_result_i;
	end

endmodule

`default_nettype wire

/* verilog/mult_block_seq.sv */
`timescale 1ns/1ps
`default_nettype none
`include "x25519_defs.svh"

module mult_block_seq import x25519_pkg::*; (
	input wire clk,
	input wire rst_n_i,
	input wire mult_en_i,
	input wire [`X25519_OPER_W-1:0] oper_a_i,
	input wire [`X25519_OPER_W-1:0] oper_b_i,
	input wire pass_valid_i,
	output logic pass_en_o,
	output logic [4:0] pass_idx_o,
	output bignum_t a_big_o,
	output bignum_t b_rot_o
);

	localparam int BLOCKS  = `X25519_BLOCKS;
	localparam int BLOCK_W = `X25519_BLOCK_W;
	localparam int PAD_W   = `X25519_WORD_W - `X25519_BLOCK_W;

	bignum_t b_big;
	logic next_en;

	// Byte blocks zero extended into 32-bit words
	function automatic bignum_t to_bignum(input logic [`X25519_OPER_W-1:0] v);
		bignum_t r;
		for (int k = 0; k < BLOCKS; k++) begin
			r.blocks[k] = {{PAD_W{1'b0}}, v[k*BLOCK_W +: BLOCK_W]};
		end
		return r;
	endfunction

	assign a_big_o = to_bignum(oper_a_i);
	assign b_big   = to_bignum(oper_b_i);

	// First pass on mult_en, then one more per finished pass up to column 31
	assign next_en = mult_en_i || (pass_valid_i && (pass_idx_o != 5'(BLOCKS - 1)));

	//////////////////////////////////////////////////////////////////////
	// Pass counter

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pass_en_o  <= 1'b0;
			pass_idx_o <= '0;
		end else begin
			pass_en_o <= next_en;
			if (mult_en_i)
				pass_idx_o <= '0;
			else if (pass_valid_i)
				pass_idx_o <= pass_idx_o + 5'd1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// B rotation

	// After the load, b_rot[k] holds b[(i - k) mod 32] during pass i
	always_ff @(posedge clk) begin
		if (next_en) begin
			if (mult_en_i) begin
				// Block 0 stays, the rest go in reversed order
				b_rot_o.blocks[0] <= b_big.blocks[0];
				for (int k = 1; k < BLOCKS; k++)
					b_rot_o.blocks[k] <= b_big.blocks[BLOCKS-k];
			end else begin
				// Rotate up by one block, top wraps to block 0
				b_rot_o.blocks[0] <= b_rot_o.blocks[BLOCKS-1];
				for (int k = 1; k < BLOCKS; k++)
					b_rot_o.blocks[k] <= b_rot_o.blocks[k-1];
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/mult_pass.sv */
`timescale 1ns/1ps
`default_nettype none
`include "x25519_defs.svh"

module mult_pass import x25519_pkg::*; (
	input wire clk,
	input wire rst_n_i,
	input wire pass_en_i,
	input wire [4:0] pass_idx_i,
	input wire bignum_t a_big_i,
	input wire bignum_t b_rot_i,
	output logic pass_valid_o,
	output logic [`X25519_WORD_W-1:0] pass_col_o
);

	localparam int BLOCKS  = `X25519_BLOCKS;
	localparam int BLOCK_W = `X25519_BLOCK_W;
	localparam int WORD_W  = `X25519_WORD_W;

	// 2^256 is 38 mod p
	localparam logic [WORD_W-1:0] WRAP_MUL = 38;

	logic [BLOCKS-1:0][WORD_W-1:0] prod_d;
	logic [BLOCKS-1:0][WORD_W-1:0] prod_q;
	logic [WORD_W-1:0] col_sum;
	logic stage1_valid_q;

	//////////////////////////////////////////////////////////////////////
	// Stage one, block products

	always_comb begin
		for (int j = 0; j < BLOCKS; j++) begin
			// 8x8 product of the aligned blocks
			prod_d[j] = WORD_W'(a_big_i.blocks[j][BLOCK_W-1:0])
				* WORD_W'(b_rot_i.blocks[j][BLOCK_W-1:0]);
			// Pair j, (i - j) wrapped past block 31 when j > i
			if (j > int'(pass_idx_i))
				prod_d[j] = prod_d[j] * WRAP_MUL;
		end
	end

	always_ff @(posedge clk) begin
		if (pass_en_i)
			prod_q <= prod_d;
	end

	//////////////////////////////////////////////////////////////////////
	// Stage two, column sum

	// Worst case sum stays under 2^27
	always_comb begin
		col_sum = '0;
		for (int j = 0; j < BLOCKS; j++)
			col_sum = col_sum + prod_q[j];
	end

	always_ff @(posedge clk) begin
		if (stage1_valid_q)
			pass_col_o <= col_sum;
	end

	// Valid pipe, two cycles from pass_en
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			stage1_valid_q <= 1'b0;
			pass_valid_o   <= 1'b0;
		end else begin
			stage1_valid_q <= pass_en_i;
			pass_valid_o   <= stage1_valid_q;
		end
	end

endmodule

`default_nettype wire

/* verilog/streaming_squeeze.sv */
`timescale 1ns/1ps
`default_nettype none
`include "x25519_defs.svh"

module streaming_squeeze import x25519_pkg::*; (
	input wire clk,
	input wire rst_n_i,
	input wire clear_i,
	input wire col_valid_i,
	input wire [`X25519_WORD_W-1:0] col_i,
	output logic sq_valid_o,
	output logic [`X25519_RES_W-1:0] sq_result_o
);

	localparam int BLOCKS  = `X25519_BLOCKS;
	localparam int BLOCK_W = `X25519_BLOCK_W;
	localparam int WORD_W  = `X25519_WORD_W;
	localparam int OPER_W  = `X25519_OPER_W;
	localparam int PAD_W   = `X25519_RES_W - `X25519_OPER_W;
	localparam int CNT_W   = $clog2(`X25519_BLOCKS);

	// 2^255 is 19 mod p
	localparam logic [WORD_W-1:0] FOLD_MUL = 19;

	squeeze_state_e state_q;
	logic [CNT_W-1:0] col_cnt_q;
	logic [WORD_W-1:0] carry_q;
	logic [WORD_W-1:0] ovf_q;
	logic [OPER_W-1:0] red_q;
	logic [WORD_W-1:0] acc;

	// Incoming column plus carry from the block below
	assign acc = carry_q + col_i;

	// Upper blocks of the result are always zero
	assign sq_result_o = {{PAD_W{1'b0}}, red_q};

	//////////////////////////////////////////////////////////////////////
	// Control FSM

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q    <= COLLECT;
			col_cnt_q  <= '0;
			sq_valid_o <= 1'b0;
		end else begin
			sq_valid_o <= 1'b0;
			if (clear_i) begin
				state_q   <= COLLECT;
				col_cnt_q <= '0;
			end else begin
				case (state_q)
					COLLECT: begin
						if (col_valid_i) begin
							col_cnt_q <= col_cnt_q + 1'b1;
							if (col_cnt_q == CNT_W'(BLOCKS - 1))
								state_q <= CARRY1;
						end
					end
					CARRY1:  state_q <= FOLD;
					FOLD:    state_q <= CARRY2;
					CARRY2: begin
						state_q    <= COLLECT;
						sq_valid_o <= 1'b1;
					end
					default: state_q <= COLLECT;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Datapath

	always_ff @(posedge clk) begin
		if (clear_i) begin
			carry_q <= '0;
		end else begin
			case (state_q)
				COLLECT: begin
					// Low byte lands in its block, the rest rides up
					if (col_valid_i) begin
						red_q[col_cnt_q*BLOCK_W +: BLOCK_W] <= acc[BLOCK_W-1:0];
						carry_q <= acc >> BLOCK_W;
					end
				end
				CARRY1: begin
					// Everything at or above bit 255, block 31 kept to 7 bits
					ovf_q <= {carry_q[WORD_W-2:0], red_q[OPER_W-1]};
					red_q[OPER_W-1] <= 1'b0;
				end
				FOLD: begin
					red_q <= red_q + OPER_W'(ovf_q * FOLD_MUL);
				end
				CARRY2: begin
					// Fold can spill one bit into 255, fold it once more
					red_q <= {1'b0, red_q[OPER_W-2:0]}
						+ (red_q[OPER_W-1] ? OPER_W'(FOLD_MUL) : '0);
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/x25519_mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "x25519_defs.svh"

module x25519_mul_unit import x25519_pkg::*; (
	input wire clk,
	input wire rst_n_i,
	input wire start_i,
	input wire mul_op_e op_i,
	input wire [`X25519_OPER_W-1:0] a_i,
	input wire [`X25519_OPER_W-1:0] b_i,
	output logic busy_o,
	output logic done_o,
	output logic [`X25519_RES_W-1:0] result_o
);

	// Command side
	logic mult_en;
	logic [`X25519_OPER_W-1:0] oper_a;
	logic [`X25519_OPER_W-1:0] oper_b;

	// Pass side
	logic pass_en;
	logic [4:0] pass_idx;
	bignum_t a_big;
	bignum_t b_rot;
	logic pass_valid;
	logic [`X25519_WORD_W-1:0] pass_col;

	// Reducer side
	logic sq_valid;
	logic [`X25519_RES_W-1:0] sq_result;

	//////////////////////////////////////////////////////////////////////
	// Command registers

	mul_cmd_regs mul_cmd_regs_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.start_i     (start_i),
		.op_i        (op_i),
		.a_i         (a_i),
		.b_i         (b_i),
		.sq_valid_i  (sq_valid),
		.sq_result_i (sq_result),
		.mult_en_o   (mult_en),
		.oper_a_o    (oper_a),
		.oper_b_o    (oper_b),
		.busy_o      (busy_o),
		.done_o      (done_o),
		.result_o    (result_o)
	);

	//////////////////////////////////////////////////////////////////////
	// Block serial multiplier

	mult_block_seq mult_block_seq_i (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.mult_en_i    (mult_en),
		.oper_a_i     (oper_a),
		.oper_b_i     (oper_b),
		.pass_valid_i (pass_valid),
		.pass_en_o    (pass_en),
		.pass_idx_o   (pass_idx),
		.a_big_o      (a_big),
		.b_rot_o      (b_rot)
	);

	mult_pass mult_pass_i (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.pass_en_i    (pass_en),
		.pass_idx_i   (pass_idx),
		.a_big_i      (a_big),
		.b_rot_i      (b_rot),
		.pass_valid_o (pass_valid),
		.pass_col_o   (pass_col)
	);

	// Reducer restarts with each new run
	streaming_squeeze streaming_squeeze_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.clear_i     (mult_en),
		.col_valid_i (pass_valid),
		.col_i       (pass_col),
		.sq_valid_o  (sq_valid),
		.sq_result_o (sq_result)
	);

endmodule

`default_nettype wire

/* verification/tb_x25519_mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "x25519_defs.svh"

module tb_x25519_mul_unit import x25519_pkg::*; ();

	localparam int CLK_PERIOD   = 4;
	localparam int NUM_CORNER   = 6;
	localparam int NUM_FIXED    = NUM_CORNER * NUM_CORNER + NUM_CORNER;
	localparam int NUM_RAND     = 16;
	localparam int NUM_ROWS     = NUM_FIXED + NUM_RAND;
	localparam int ROW_LIMIT    = 400;
	localparam int QUIET_CYCLES = 8;

	// Field prime 2^255 - 19
	localparam logic [`X25519_OPER_W-1:0] P = (256'd1 << 255) - 256'd19;

	logic clk;
	logic rst_n_i;
	logic start_i;
	mul_op_e op_i;
	logic [`X25519_OPER_W-1:0] a_i;
	logic [`X25519_OPER_W-1:0] b_i;
	logic busy_o;
	logic done_o;
	logic [`X25519_RES_W-1:0] result_o;

	// Stimulus table with one request per row
	mul_op_e tbl_op [NUM_ROWS];
	logic [`X25519_OPER_W-1:0] tbl_a [NUM_ROWS];
	logic [`X25519_OPER_W-1:0] tbl_b [NUM_ROWS];
	logic tbl_busy [NUM_ROWS];
	logic [`X25519_OPER_W-1:0] corner [NUM_CORNER];

	int n_checks;
	int n_errors;
	int unsigned seed;

	x25519_mul_unit x25519_mul_unit_i (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.start_i  (start_i),
		.op_i     (op_i),
		.a_i      (a_i),
		.b_i      (b_i),
		.busy_o   (busy_o),
		.done_o   (done_o),
		.result_o (result_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model and compare tasks

	// Full 512-bit product reduced to the canonical value
	function automatic logic [254:0] mod_product(input logic [255:0] a, input logic [255:0] b);
		logic [511:0] prod;
		logic [511:0] rem;
		prod = {256'b0, a} * {256'b0, b};
		rem  = prod % {256'b0, P};
		return rem[254:0];
	endfunction

	function automatic logic [`X25519_OPER_W-1:0] rand_operand();
		logic [`X25519_OPER_W-1:0] v;
		for (int k = 0; k < 8; k++)
			v[k*32 +: 32] = $urandom();
		return v;
	endfunction

	task automatic check_result(input mul_op_e op, input logic [254:0] exp,
			input logic [`X25519_RES_W-1:0] got);
		logic [`X25519_RES_W-1:0] red;
		string label;
		label = (op == MUL_OP_SQR) ? "SQR" : "MUL";
		// Partial result only has to be congruent
		red = got % {8'b0, P};
		n_checks++;
		if (red !== {9'b0, exp}) begin
			n_errors++;
			$display("FAIL t=%0t result_o (%s mod p) exp=%h got=%h",
				$time, label, exp, red[254:0]);
		end
	endtask

	task automatic check_bound(input logic [`X25519_RES_W-1:0] got);
		n_checks++;
		// Bits 263:255 must all be clear
		if (got[`X25519_RES_W-1:255] !== '0) begin
			n_errors++;
			$display("FAIL t=%0t result_o[263:255] exp=000 got=%h",
				$time, got[`X25519_RES_W-1:255]);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic got);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAIL t=%0t %s exp=%b got=%b", $time, name, exp, got);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Table build and row driver

	task automatic build_table();
		corner[0] = '0;
		corner[1] = 256'd1;
		corner[2] = P - 256'd1;
		corner[3] = P;
		corner[4] = {1'b0, {255{1'b1}}};
		corner[5] = '1;
		// Every corner pair multiplied and then each corner squared
		for (int r = 0; r < NUM_CORNER * NUM_CORNER; r++) begin
			tbl_op[r] = MUL_OP_MUL;
			tbl_a[r]  = corner[r / NUM_CORNER];
			tbl_b[r]  = corner[r % NUM_CORNER];
		end
		for (int k = 0; k < NUM_CORNER; k++) begin
			tbl_op[NUM_CORNER*NUM_CORNER+k] = MUL_OP_SQR;
			tbl_a[NUM_CORNER*NUM_CORNER+k]  = corner[k];
			// b_i is junk for squares
			tbl_b[NUM_CORNER*NUM_CORNER+k]  = corner[NUM_CORNER-1-k];
		end
		for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
			tbl_op[r] = ($urandom() % 2) ? MUL_OP_SQR : MUL_OP_MUL;
			tbl_a[r]  = rand_operand();
			tbl_b[r]  = rand_operand();
		end
		for (int r = 0; r < NUM_ROWS; r++)
			tbl_busy[r] = (r % 4 == 1);
	endtask

	task automatic run_row(input int r);
		logic [254:0] exp;
		int waited;
		int errs_before;
		errs_before = n_errors;
		exp = mod_product(tbl_a[r], (tbl_op[r] == MUL_OP_SQR) ? tbl_a[r] : tbl_b[r]);
		@(negedge clk);
		start_i = 1'b1;
		op_i    = tbl_op[r];
		a_i     = tbl_a[r];
		b_i     = tbl_b[r];
		@(negedge clk);
		start_i = 1'b0;
		check_flag("busy_o", 1'b1, busy_o);
		// Second request with other operands lands mid run
		if (tbl_busy[r]) begin
			repeat (3) @(negedge clk);
			start_i = 1'b1;
			op_i    = (tbl_op[r] == MUL_OP_MUL) ? MUL_OP_SQR : MUL_OP_MUL;
			a_i     = ~tbl_a[r];
			b_i     = ~tbl_b[r];
			@(negedge clk);
			start_i = 1'b0;
			check_flag("busy_o", 1'b1, busy_o);
		end
		waited = 0;
		while (!done_o && waited < ROW_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!done_o) begin
			n_errors++;
			$display("row %0d: done_o did not arrive within %0d cycles", r, ROW_LIMIT);
		end else begin
			check_result(tbl_op[r], exp, result_o);
			check_bound(result_o);
			check_flag("busy_o", 1'b0, busy_o);
			// Exactly one pulse and no restart afterwards
			repeat (QUIET_CYCLES) begin
				@(negedge clk);
				check_flag("done_o", 1'b0, done_o);
			end
			check_flag("busy_o", 1'b0, busy_o);
		end
		$display("row %0d %s busy_start=%0b: %0d error(s)", r,
			(tbl_op[r] == MUL_OP_SQR) ? "SQR" : "MUL", tbl_busy[r], n_errors - errs_before);
	endtask

	// A dropped start must not come back as a late run
	task automatic watch_idle_tail();
		logic late_done;
		logic late_busy;
		late_done = 1'b0;
		late_busy = 1'b0;
		// Longer than any single run
		repeat (ROW_LIMIT) begin
			@(negedge clk);
			late_done = late_done | done_o;
			late_busy = late_busy | busy_o;
		end
		check_flag("done_o", 1'b0, late_done);
		check_flag("busy_o", 1'b0, late_busy);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog

	initial begin
		rst_n_i  = 1'b0;
		start_i  = 1'b0;
		op_i     = MUL_OP_MUL;
		a_i      = '0;
		b_i      = '0;
		n_checks = 0;
		n_errors = 0;
		seed     = 32'h25adecab;
		void'($urandom(seed));
		build_table();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;
		// Idle outputs straight out of reset
		check_flag("busy_o", 1'b0, busy_o);
		check_flag("done_o", 1'b0, done_o);
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);
		// Last row may have carried an ignored start
		watch_idle_tail();
		$display("rows %0d, checks %0d, errors %0d", NUM_ROWS, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin
		repeat ((NUM_ROWS + 2) * 200) @(posedge clk);
		$display("Watchdog expired before all rows finished");
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+verilog
verilog/x25519_pkg.sv
verilog/mul_cmd_regs.sv
verilog/mult_block_seq.sv
verilog/mult_pass.sv
verilog/streaming_squeeze.sv
verilog/x25519_mul_unit.sv
verification/tb_x25519_mul_unit.sv
